/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f sources.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim | tee sim.log \
    && grep -q "^SIMULATION PASSED$" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

/* source/dbg_print_pkg.sv */
package dbg_print_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  char_t;
    typedef logic [7:0]  cmd_t;
    typedef logic [3:0]  field_idx_t;
    typedef logic [1:0]  char_idx_t;

    typedef enum logic {
        ITEM_CHAR = 1'b0,
        ITEM_WORD = 1'b1
    } item_kind_t;

    localparam field_idx_t NUM_FIELDS = 4'd9;

    localparam char_t ASCII_EQ = 8'h3D;
    localparam char_t ASCII_CR = 8'h0D;
    localparam char_t ASCII_LF = 8'h0A;

    // Label text without "=", packed left aligned, three characters max
    function automatic logic [23:0] label_text(field_idx_t field);
        case (field)
            4'd0:    return 24'h4E5043; // NPC
            4'd1:    return 24'h504300; // PC
            4'd2:    return 24'h495200; // IR
            4'd3:    return 24'h43544C; // CTL
            4'd4:    return 24'h410000; // A
            4'd5:    return 24'h420000; // B
            4'd6:    return 24'h494D4D; // IMM
            4'd7:    return 24'h590000; // Y
            default: return 24'h4D4452; // MDR
        endcase
    endfunction

    function automatic char_t label_char(field_idx_t field, char_idx_t idx);
        logic [23:0] text;
        text = label_text(field);
        return text[23 - 8 * idx -: 8];
    endfunction

    function automatic char_idx_t label_len(field_idx_t field);
        case (field)
            4'd1, 4'd2:       return 2'd2;
            4'd4, 4'd5, 4'd7: return 2'd1;
            default:          return 2'd3;
        endcase
    endfunction

endpackage

/* source/dbg_print_top.sv */
`timescale 1ns/100ps

module dbg_print_top
    import dbg_print_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rstn,
    input  cmd_t       sel_mode,
    input  cmd_t       cmd_print,
    input  word_t      npc,
    input  word_t      pc,
    input  word_t      ir,
    input  word_t      ctl,
    input  word_t      a,
    input  word_t      b,
    input  word_t      imm,
    input  word_t      y,
    input  word_t      mdr,
    input  logic       ack_tx,
    output logic       req_tx,
    output item_kind_t type_tx,
    output word_t      dout,
    output logic       finish
);

    logic       enable;
    logic       wr_en;
    item_kind_t wr_kind;
    word_t      wr_data;
    logic       wr_last;
    logic       flush;
    logic       rd_en;
    item_kind_t rd_kind;
    word_t      rd_data;
    logic       rd_last;
    logic       empty;
    logic       full;
    logic       dump_done;

    assign enable = (sel_mode == cmd_print);
    assign finish = dump_done;

    dump_sequencer u_seq (
        .clk(clk), .rstn(rstn), .enable(enable),
        .npc(npc), .pc(pc), .ir(ir), .ctl(ctl), .a(a), .b(b),
        .imm(imm), .y(y), .mdr(mdr),
        .full(full), .dump_done(dump_done),
        .wr_en(wr_en), .wr_kind(wr_kind), .wr_data(wr_data),
        .wr_last(wr_last), .flush(flush)
    );

    print_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rstn(rstn), .flush(flush),
        .wr_en(wr_en), .wr_kind(wr_kind), .wr_data(wr_data), .wr_last(wr_last),
        .rd_en(rd_en), .rd_kind(rd_kind), .rd_data(rd_data), .rd_last(rd_last),
        .empty(empty), .full(full)
    );

    tx_port u_tx (
        .clk(clk), .rstn(rstn), .enable(enable),
        .rd_kind(rd_kind), .rd_data(rd_data), .rd_last(rd_last), .empty(empty),
        .ack_tx(ack_tx), .rd_en(rd_en), .req_tx(req_tx), .type_tx(type_tx),
        .dout(dout), .dump_done(dump_done)
    );

endmodule

/* source/dump_sequencer.sv */
`timescale 1ns/100ps

module dump_sequencer
    import dbg_print_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       enable,
    input  word_t      npc,
    input  word_t      pc,
    input  word_t      ir,
    input  word_t      ctl,
    input  word_t      a,
    input  word_t      b,
    input  word_t      imm,
    input  word_t      y,
    input  word_t      mdr,
    input  logic       full,
    input  logic       dump_done,
    output logic       wr_en,
    output item_kind_t wr_kind,
    output word_t      wr_data,
    output logic       wr_last,
    output logic       flush
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LABEL,
        SEQ_EQ,
        SEQ_WORD,
        SEQ_CR,
        SEQ_LF,
        SEQ_WAIT
    } seq_state_t;

    seq_state_t state;
    field_idx_t field_idx;
    char_idx_t  char_idx;
    logic       enable_q;
    logic       emit;
    word_t      field_word;

    always_comb begin
        case (field_idx)
            4'd0:    field_word = npc;
            4'd1:    field_word = pc;
            4'd2:    field_word = ir;
            4'd3:    field_word = ctl;
            4'd4:    field_word = a;
            4'd5:    field_word = b;
            4'd6:    field_word = imm;
            4'd7:    field_word = y;
            default: field_word = mdr;
        endcase
    end

    always_comb begin
        emit    = 1'b1;
        wr_kind = ITEM_CHAR;
        wr_data = '0;
        wr_last = 1'b0;
        case (state)
            SEQ_LABEL: wr_data = word_t'(label_char(field_idx, char_idx));
            SEQ_EQ:    wr_data = word_t'(ASCII_EQ);
            SEQ_WORD: begin
                wr_kind = ITEM_WORD;
                wr_data = field_word; // Sampled as it enters the FIFO
            end
            SEQ_CR:    wr_data = word_t'(ASCII_CR);
            SEQ_LF: begin
                wr_data = word_t'(ASCII_LF);
                wr_last = 1'b1;
            end
            default:   emit = 1'b0;
        endcase
    end

    assign wr_en = emit && enable && !full;
    assign flush = enable_q && !enable; // Falling edge of enable

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= SEQ_IDLE;
            field_idx <= '0;
            char_idx  <= '0;
            enable_q  <= 1'b0;
        end else begin
            enable_q <= enable;
            if (!enable) begin
                state     <= SEQ_IDLE;
                field_idx <= '0;
                char_idx  <= '0;
            end else begin
                case (state)
                    SEQ_IDLE: begin
                        state     <= SEQ_LABEL;
                        field_idx <= '0;
                        char_idx  <= '0;
                    end
                    SEQ_LABEL: if (wr_en) begin
                        if (char_idx == label_len(field_idx) - 2'd1) begin
                            state    <= SEQ_EQ;
                            char_idx <= '0;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end
                    SEQ_EQ: if (wr_en) state <= SEQ_WORD;
                    SEQ_WORD: if (wr_en) begin
                        if (field_idx == NUM_FIELDS - 4'd1) begin
                            state <= SEQ_CR;
                        end else begin
                            field_idx <= field_idx + 4'd1;
                            state     <= SEQ_LABEL;
                        end
                    end
                    SEQ_CR: if (wr_en) state <= SEQ_LF;
                    SEQ_LF: if (wr_en) state <= SEQ_WAIT;
                    SEQ_WAIT: if (dump_done) begin // Next dump right away
                        state     <= SEQ_LABEL;
                        field_idx <= '0;
                        char_idx  <= '0;
                    end
                    default: state <= SEQ_IDLE;
                endcase
            end
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> !full);

    a_field_idx_range: assert property (@(posedge clk) disable iff (!rstn)
        field_idx <= NUM_FIELDS - 4'd1);

endmodule

/* source/print_fifo.sv */
`timescale 1ns/100ps

module print_fifo
    import dbg_print_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       flush,
    input  logic       wr_en,
    input  item_kind_t wr_kind,
    input  word_t      wr_data,
    input  logic       wr_last,
    input  logic       rd_en,
    output item_kind_t rd_kind,
    output word_t      rd_data,
    output logic       rd_last,
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(DEPTH);

    item_kind_t     kind_mem [DEPTH];
    word_t          data_mem [DEPTH];
    logic           last_mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;

    assign empty = (count == '0);
    assign full  = (count == (AW + 1)'(DEPTH));

    // Head item straight from storage
    assign rd_kind = kind_mem[rd_ptr];
    assign rd_data = data_mem[rd_ptr];
    assign rd_last = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            kind_mem[wr_ptr] <= wr_kind;
            data_mem[wr_ptr] <= wr_data;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en && !full) wr_ptr <= wr_ptr + 1'b1; // Wraps at power of two
            if (rd_en && !empty) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en && !full, rd_en && !empty})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        rd_en |-> !empty);

endmodule

/* source/tx_port.sv */
`timescale 1ns/100ps

module tx_port
    import dbg_print_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       enable,
    input  item_kind_t rd_kind,
    input  word_t      rd_data,
    input  logic       rd_last,
    input  logic       empty,
    input  logic       ack_tx,
    output logic       rd_en,
    output logic       req_tx,
    output item_kind_t type_tx,
    output word_t      dout,
    output logic       dump_done
);

    typedef enum logic {
        TX_IDLE,
        TX_REQ
    } tx_state_t;

    tx_state_t state;
    logic      last_q;
    logic      load;

    assign load   = (state == TX_IDLE) && enable && !empty;
    assign rd_en  = (state == TX_REQ) && enable && ack_tx; // Pop on the ack
    assign req_tx = (state == TX_REQ);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= TX_IDLE;
            dump_done <= 1'b0;
        end else begin
            dump_done <= 1'b0;
            if (!enable) begin
                state <= TX_IDLE; // Abort drops the request
            end else begin
                case (state)
                    TX_IDLE: if (!empty) state <= TX_REQ;
                    TX_REQ: if (ack_tx) begin
                        state     <= TX_IDLE;
                        dump_done <= last_q;
                    end
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dout    <= rd_data;
            type_tx <= rd_kind;
            last_q  <= rd_last;
        end
    end

    // Item held steady until the receiver takes it
    a_stable_while_req: assert property (@(posedge clk) disable iff (!rstn)
        (req_tx && !ack_tx) |=> ($stable(dout) && $stable(type_tx)));

endmodule

/* sources.f */
source/dbg_print_pkg.sv
source/dump_sequencer.sv
source/print_fifo.sv
source/tx_port.sv
source/dbg_print_top.sv
verif/clk_gen.sv
verif/tb_top.sv

/* verif/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1; // Released on a rising edge
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/100ps

module tb_top
    import dbg_print_pkg::*;
();

    logic        clk;
    logic        rstn;
    cmd_t        sel_mode;
    cmd_t        cmd_print;
    word_t       fields [9];
    logic        ack_tx = 1'b0;
    logic        req_tx;
    item_kind_t  type_tx;
    word_t       dout;
    logic        finish;

    string       labels [9] = '{"NPC", "PC", "IR", "CTL", "A", "B", "IMM", "Y", "MDR"};
    item_kind_t  exp_kind [64];
    word_t       exp_data [64];
    int          exp_len = 0;
    item_kind_t  exp_kind_cur;
    word_t       exp_data_cur;
    int          xfer_idx = 0;
    logic        print_en;
    logic        xfer;
    logic        xfer_last;
    logic        xfer_mid;
    logic [31:0] field_lfsr = 32'hd8f6;
    logic [31:0] ack_lfsr = 32'hd8f6;
    logic [31:0] delay_bits;
    logic [1:0]  ack_wait = 2'd0;
    logic        ack_random = 1'b0;
    string       test_name = "init";
    int          err_count = 0;
    int          errs_at_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    bit          timed_out = 1'b0;

    clk_gen u_clk_gen (.clk(clk), .rstn(rstn));

    dbg_print_top u_dut (
        .clk(clk), .rstn(rstn), .sel_mode(sel_mode), .cmd_print(cmd_print),
        .npc(fields[0]), .pc(fields[1]), .ir(fields[2]), .ctl(fields[3]),
        .a(fields[4]), .b(fields[5]), .imm(fields[6]), .y(fields[7]), .mdr(fields[8]),
        .ack_tx(ack_tx), .req_tx(req_tx), .type_tx(type_tx), .dout(dout), .finish(finish)
    );

    assign print_en     = (sel_mode == cmd_print);
    assign xfer         = req_tx && ack_tx && print_en; // Item accepted this edge
    assign xfer_last    = xfer && (xfer_idx == exp_len - 1);
    assign xfer_mid     = xfer && (xfer_idx != exp_len - 1);
    assign exp_kind_cur = exp_kind[xfer_idx];
    assign exp_data_cur = exp_data[xfer_idx];

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h80200003;
        return state >> 1;
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int nbits,
                             output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            state = lfsr_next(state);
            value = {value[30:0], state[0]};
        end
    endtask

    // Receiver holds off the ack for 0 to 3 cycles in random mode
    always @(posedge clk) begin
        if (!rstn) begin
            ack_tx   <= 1'b0;
            ack_wait <= 2'd0;
        end else if (ack_tx) begin
            ack_tx <= 1'b0;
        end else if (req_tx) begin
            if (ack_wait == 2'd0) begin
                ack_tx <= 1'b1;
                draw_bits(ack_lfsr, 2, delay_bits);
                ack_wait <= ack_random ? delay_bits[1:0] : 2'd0;
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rstn || !print_en)
            xfer_idx <= 0; // Abort restarts the dump
        else if (xfer)
            xfer_idx <= xfer_last ? 0 : xfer_idx + 1;
    end

    // New field values and the expected item list for the next dump
    task automatic load_dump;
        logic [31:0] value;
        int          n;
        int          f;
        int          c;
        n = 0;
        for (f = 0; f < 9; f++) begin
            draw_bits(field_lfsr, 32, value);
            fields[f] <= value;
            for (c = 0; c < labels[f].len(); c++) begin
                exp_kind[n] <= ITEM_CHAR;
                exp_data[n] <= {24'h000000, labels[f][c]};
                n++;
            end
            exp_kind[n] <= ITEM_CHAR;
            exp_data[n] <= 32'h0000003D;
            exp_kind[n + 1] <= ITEM_WORD;
            exp_data[n + 1] <= value;
            n += 2;
        end
        exp_kind[n] <= ITEM_CHAR;
        exp_data[n] <= 32'h0000000D;
        exp_kind[n + 1] <= ITEM_CHAR;
        exp_data[n + 1] <= 32'h0000000A;
        exp_len <= n + 2;
    endtask

    a_xfer_matches: assert property (@(posedge clk) disable iff (!rstn)
        xfer |-> (dout == exp_data_cur && type_tx == exp_kind_cur))
    else begin
        err_count++;
        $display("MISMATCH %s: item %0d expected kind %0d data %h, actual kind %0d data %h",
                 test_name, $sampled(xfer_idx), $sampled(exp_kind_cur),
                 $sampled(exp_data_cur), $sampled(type_tx), $sampled(dout));
    end

    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rstn)
        (req_tx && !ack_tx && print_en) |=> (req_tx && $stable(dout) && $stable(type_tx)))
    else begin
        err_count++;
        $display("%s: request dropped or item changed before the ack", test_name);
    end

    a_gap_after_ack: assert property (@(posedge clk) disable iff (!rstn)
        xfer_mid |=> !req_tx)
    else begin
        err_count++;
        $display("%s: req_tx still high on the cycle after an ack", test_name);
    end

    a_next_req: assert property (@(posedge clk) disable iff (!rstn)
        ($past(xfer_mid, 2) && $past(print_en)) |-> req_tx)
    else begin
        err_count++;
        $display("%s: req_tx low for more than one cycle inside a dump", test_name);
    end

    a_finish_after_lf: assert property (@(posedge clk) disable iff (!rstn)
        1'b1 |-> (finish == $past(xfer_last)))
    else begin
        err_count++;
        $display("MISMATCH %s: finish expected %0b, actual %0b",
                 test_name, $past(xfer_last), $sampled(finish));
    end

    a_finish_single: assert property (@(posedge clk) disable iff (!rstn)
        finish |=> !finish)
    else begin
        err_count++;
        $display("%s: finish held high for more than one cycle", test_name);
    end

    a_quiet_when_off: assert property (@(posedge clk) disable iff (!rstn)
        !print_en |=> (!req_tx && !finish))
    else begin
        err_count++;
        $display("%s: req_tx or finish active while printing is disabled", test_name);
    end

    task automatic idle_cycles(input int count);
        int i;
        for (i = 0; i < count; i++)
            @(posedge clk);
    endtask

    task automatic wait_for_finish(input int max_cycles);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles) begin
            @(posedge clk);
            n++;
            seen = finish;
        end
        if (!seen) begin
            $display("%s: no finish pulse within %0d cycles", test_name, max_cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_item(input int idx, input int max_cycles);
        int n;
        n = 0;
        while (xfer_idx < idx && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (xfer_idx < idx) begin
            $display("%s: item %0d not reached within %0d cycles", test_name, idx, max_cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test;
        if (!timed_out && err_count == errs_at_start) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d check errors", test_name, err_count - errs_at_start);
        end
    endtask

    initial begin
        int n;
        sel_mode  = 8'h00;
        cmd_print = 8'hA5;
        for (n = 0; n < 9; n++)
            fields[n] = '0;
        n = 0;
        while (rstn !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("reset never released");
            timed_out = 1'b1;
        end

        begin_test("reset");
        idle_cycles(8); // Disabled so nothing may come out
        end_test();

        if (!timed_out) begin
            begin_test("full_dump");
            ack_random <= 1'b0;
            load_dump();
            sel_mode <= cmd_print;
            wait_for_finish(500);
            end_test();
        end

        if (!timed_out) begin
            begin_test("back_pressure");
            ack_random <= 1'b1;
            load_dump();
            wait_for_finish(1500);
            end_test();
        end

        if (!timed_out) begin
            begin_test("finish_pulse");
            load_dump();
            wait_for_finish(1500);
            end_test();
        end

        if (!timed_out) begin
            begin_test("abort");
            load_dump();
            wait_for_item(12, 600);
            if (!timed_out) begin
                sel_mode <= ~cmd_print; // Drop out mid dump
                idle_cycles(3);
                load_dump();
                sel_mode <= cmd_print;
                wait_for_finish(1500);
            end
            end_test();
        end

        sel_mode <= 8'h00;
        idle_cycles(4);
        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 pass_count, fail_count, err_count);
        if (timed_out || err_count != 0 || fail_count != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule
